/* hdl/fir_cfg.svh */
// FIR engine widths, tap count and AXI-Lite register map; include wherever these are needed
`ifndef FIR_CFG_SVH
`define FIR_CFG_SVH

// sample, coefficient and bus data width
`define FIR_DATA_W      32
// AXI-Lite byte address width
`define FIR_ADDR_W      12
// filter length and index width for taps and history slots
`define FIR_NUM_TAPS    11
`define FIR_TAP_IDX_W   4

// register map, tap i lives at TAP0 + 4*i
`define FIR_ADDR_CTRL   12'h000
`define FIR_ADDR_LEN    12'h010
`define FIR_ADDR_TAP0   12'h020

// bit positions inside the control word
`define FIR_BIT_START   0
`define FIR_BIT_DONE    1
`define FIR_BIT_IDLE    2

`endif

/* hdl/fir_pkg.sv */
// shared types of the FIR engine; compile before the RTL and reference as fir_pkg::name
`default_nettype none

`include "fir_cfg.svh"

package fir_pkg;

    // dataflow engine states
    typedef enum logic [1:0] {
        eng_idle,
        eng_wait_in,
        eng_mac,
        eng_out_hold
    } eng_state_e;

    // AXI-Lite front end states
    typedef enum logic {
        axil_idle,
        axil_read_resp
    } axil_state_e;

    // one register access, strobes last a single cycle
    typedef struct packed {
        logic                   wr;
        logic                   rd;
        logic [`FIR_ADDR_W-1:0] addr;
        logic [`FIR_DATA_W-1:0] wdata;
    } cfg_req_t;

    // register block to engine
    typedef struct packed {
        logic                   start;
        logic [`FIR_DATA_W-1:0] len;
    } run_ctrl_t;

endpackage

`default_nettype wire

/* hdl/fir_axil_slave.sv */
// AXI-Lite slave front end of the FIR engine, turns bus reads and writes into cfg requests
`timescale 1ns/100ps
`default_nettype none

`include "fir_cfg.svh"

module fir_axil_slave (
    input  logic                   axis_clk,
    input  logic                   axis_rst_n,
    input  logic                   awvalid,
    input  logic [`FIR_ADDR_W-1:0] awaddr,
    output logic                   awready,
    input  logic                   wvalid,
    input  logic [`FIR_DATA_W-1:0] wdata,
    output logic                   wready,
    input  logic                   arvalid,
    input  logic [`FIR_ADDR_W-1:0] araddr,
    output logic                   arready,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [`FIR_DATA_W-1:0] rdata,
    output fir_pkg::cfg_req_t      cfg_req,
    input  logic [`FIR_DATA_W-1:0] rd_data
);

    fir_pkg::axil_state_e   state;
    logic                   rd_go;
    logic                   wr_go;
    logic                   wr_xfer;
    logic                   rd_xfer;
    logic                   req_wr;
    logic                   req_rd;
    logic [`FIR_ADDR_W-1:0] req_addr;
    logic [`FIR_DATA_W-1:0] req_wdata;

    // read wins a tie, a write needs both address and data present
    assign rd_go = (state == fir_pkg::axil_idle) && arvalid && !awready;
    assign wr_go = (state == fir_pkg::axil_idle) && !arvalid && awvalid && wvalid && !awready;

    assign wr_xfer = awready && awvalid && wvalid;
    assign rd_xfer = arready && arvalid;

    // aw and w channels accept together
    assign wready = awready;

    assign cfg_req.wr    = req_wr;
    assign cfg_req.rd    = req_rd;
    assign cfg_req.addr  = req_addr;
    assign cfg_req.wdata = req_wdata;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state   <= fir_pkg::axil_idle;
            awready <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            req_wr  <= 1'b0;
            req_rd  <= 1'b0;
        end else begin
            // single cycle ready pulse
            awready <= wr_go;
            // write strobe the cycle after the handshake
            req_wr  <= wr_xfer;
            req_rd  <= rd_go;
            // register block answers one cycle after the strobe, ready lines up with it
            arready <= req_rd;
            case (state)
                fir_pkg::axil_idle: begin
                    if (rd_go) begin
                        state <= fir_pkg::axil_read_resp;
                    end
                end
                fir_pkg::axil_read_resp: begin
                    if (rd_xfer) begin
                        rvalid <= 1'b1;
                    end else if (rvalid && rready) begin
                        rvalid <= 1'b0;
                        state  <= fir_pkg::axil_idle;
                    end
                end
                default: state <= fir_pkg::axil_idle;
            endcase
        end
    end

    // address, write data and read data payload
    always_ff @(posedge axis_clk) begin
        if (rd_go) begin
            req_addr <= araddr;
        end else if (wr_xfer) begin
            req_addr  <= awaddr;
            req_wdata <= wdata;
        end
        // held stable until rready
        if (rd_xfer) begin
            rdata <= rd_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/fir_ctrl_regs.sv */
// FIR register block: taps, data length and ap control bits behind the AXI-Lite front end
`timescale 1ns/100ps
`default_nettype none

`include "fir_cfg.svh"

module fir_ctrl_regs (
    input  logic                      axis_clk,
    input  logic                      axis_rst_n,
    input  fir_pkg::cfg_req_t         cfg_req,
    output logic [`FIR_DATA_W-1:0]    rd_data,
    input  logic [`FIR_TAP_IDX_W-1:0] tap_idx,
    output logic [`FIR_DATA_W-1:0]    tap_coef,
    input  logic                      block_done,
    output fir_pkg::run_ctrl_t        run
);

    localparam logic [`FIR_TAP_IDX_W-1:0] tap_count = (`FIR_TAP_IDX_W)'(`FIR_NUM_TAPS);
    localparam logic [`FIR_ADDR_W-3:0]    tap_limit = (`FIR_ADDR_W-2)'(`FIR_NUM_TAPS);

    logic [`FIR_DATA_W-1:0]    taps [`FIR_NUM_TAPS];
    logic [`FIR_DATA_W-1:0]    len_q;
    logic                      ap_done;
    logic                      ap_idle;
    logic                      start_q;
    logic                      take_start;
    logic                      hit_ctrl;
    logic                      hit_len;
    logic                      hit_tap;
    logic [`FIR_ADDR_W-1:0]    tap_off;
    logic [`FIR_TAP_IDX_W-1:0] req_idx;
    logic [`FIR_DATA_W-1:0]    rd_mux;

    // address decode
    assign tap_off  = cfg_req.addr - `FIR_ADDR_TAP0;
    assign req_idx  = tap_off[`FIR_TAP_IDX_W+1:2];
    assign hit_ctrl = (cfg_req.addr == `FIR_ADDR_CTRL);
    assign hit_len  = (cfg_req.addr == `FIR_ADDR_LEN);
    assign hit_tap  = (cfg_req.addr >= `FIR_ADDR_TAP0) && (tap_off[1:0] == 2'b00)
                      && (tap_off[`FIR_ADDR_W-1:2] < tap_limit);

    // ap_start only counts while idle
    assign take_start = cfg_req.wr && hit_ctrl && cfg_req.wdata[`FIR_BIT_START] && ap_idle;

    assign run.start = start_q;
    assign run.len   = len_q;

    // coefficient lookup for the MAC
    assign tap_coef = (tap_idx < tap_count) ? taps[tap_idx] : '0;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            for (int i = 0; i < `FIR_NUM_TAPS; i++) begin
                taps[i] <= '0;
            end
            len_q   <= '0;
            ap_done <= 1'b0;
            ap_idle <= 1'b1;
            start_q <= 1'b0;
        end else begin
            start_q <= take_start;
            if (take_start) begin
                ap_done <= 1'b0;
                ap_idle <= 1'b0;
            end else if (block_done) begin
                ap_done <= 1'b1;
                ap_idle <= 1'b1;
            end
            // taps and length frozen while a block runs
            if (cfg_req.wr && ap_idle) begin
                if (hit_len) begin
                    len_q <= cfg_req.wdata;
                end
                if (hit_tap) begin
                    taps[req_idx] <= cfg_req.wdata;
                end
            end
        end
    end

    // read back, unmapped addresses give zero
    always_comb begin
        rd_mux = '0;
        if (hit_ctrl) begin
            rd_mux[`FIR_BIT_START] = start_q;
            rd_mux[`FIR_BIT_DONE]  = ap_done;
            rd_mux[`FIR_BIT_IDLE]  = ap_idle;
        end else if (hit_len) begin
            rd_mux = len_q;
        end else if (hit_tap) begin
            rd_mux = taps[req_idx];
        end
    end

    always_ff @(posedge axis_clk) begin
        if (cfg_req.rd) begin
            rd_data <= rd_mux;
        end
    end

endmodule

`default_nettype wire

/* hdl/fir_mac_engine.sv */
// FIR dataflow: takes one stream sample, runs one MAC per tap, presents one stream output
`timescale 1ns/100ps
`default_nettype none

`include "fir_cfg.svh"

module fir_mac_engine (
    input  logic                      axis_clk,
    input  logic                      axis_rst_n,
    input  fir_pkg::run_ctrl_t        run,
    output logic [`FIR_TAP_IDX_W-1:0] tap_idx,
    input  logic [`FIR_DATA_W-1:0]    tap_coef,
    output logic                      block_done,
    input  logic                      ss_tvalid,
    input  logic [`FIR_DATA_W-1:0]    ss_tdata,
    output logic                      ss_tready,
    output logic                      sm_tvalid,
    output logic [`FIR_DATA_W-1:0]    sm_tdata,
    output logic                      sm_tlast,
    input  logic                      sm_tready
);

    localparam logic [`FIR_TAP_IDX_W-1:0] tap_last  = (`FIR_TAP_IDX_W)'(`FIR_NUM_TAPS - 1);
    localparam logic [`FIR_TAP_IDX_W-1:0] tap_count = (`FIR_TAP_IDX_W)'(`FIR_NUM_TAPS);

    fir_pkg::eng_state_e        state;
    logic [`FIR_DATA_W-1:0]     hist [`FIR_NUM_TAPS];
    logic [`FIR_TAP_IDX_W-1:0]  wr_ptr;
    logic [`FIR_TAP_IDX_W-1:0]  rd_ptr;
    logic [`FIR_DATA_W-1:0]     acc;
    logic [`FIR_DATA_W-1:0]     sum;
    logic signed [`FIR_DATA_W-1:0] prod;
    logic [`FIR_DATA_W-1:0]     out_cnt;
    logic                       in_xfer;
    logic                       out_xfer;
    logic                       start_ok;
    logic                       mac_last;

    assign ss_tready  = (state == fir_pkg::eng_wait_in);
    assign in_xfer    = ss_tvalid && ss_tready;
    assign out_xfer   = sm_tvalid && sm_tready;
    assign start_ok   = run.start && (state == fir_pkg::eng_idle);
    assign mac_last   = (state == fir_pkg::eng_mac) && (tap_idx == tap_last);
    // last output of the block taken by the sink
    assign block_done = out_xfer && sm_tlast;

    // x[n-i] sits i slots behind the newest sample, wrapping around the ring
    assign rd_ptr = (wr_ptr >= tap_idx) ? wr_ptr - tap_idx : wr_ptr + tap_count - tap_idx;

    // the one multiplier and the one adder, products wrap to data width
    assign prod = $signed(tap_coef) * $signed(hist[rd_ptr]);
    assign sum  = acc + $unsigned(prod);

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state     <= fir_pkg::eng_idle;
            wr_ptr    <= '0;
            tap_idx   <= '0;
            out_cnt   <= '0;
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end else begin
            case (state)
                fir_pkg::eng_idle: begin
                    if (start_ok) begin
                        wr_ptr  <= '0;
                        out_cnt <= '0;
                        state   <= fir_pkg::eng_wait_in;
                    end
                end
                fir_pkg::eng_wait_in: begin
                    if (in_xfer) begin
                        tap_idx <= '0;
                        state   <= fir_pkg::eng_mac;
                    end
                end
                fir_pkg::eng_mac: begin
                    if (mac_last) begin
                        // result ready one cycle after the final MAC
                        sm_tvalid <= 1'b1;
                        sm_tlast  <= ((out_cnt + 1'b1) == run.len);
                        out_cnt   <= out_cnt + 1'b1;
                        wr_ptr    <= (wr_ptr == tap_last) ? '0 : wr_ptr + 1'b1;
                        state     <= fir_pkg::eng_out_hold;
                    end else begin
                        tap_idx <= tap_idx + 1'b1;
                    end
                end
                fir_pkg::eng_out_hold: begin
                    // single output slot, no new sample until it drains
                    if (out_xfer) begin
                        sm_tvalid <= 1'b0;
                        sm_tlast  <= 1'b0;
                        state     <= sm_tlast ? fir_pkg::eng_idle : fir_pkg::eng_wait_in;
                    end
                end
                default: state <= fir_pkg::eng_idle;
            endcase
        end
    end

    // sample history, zeroed at block start
    always_ff @(posedge axis_clk) begin
        if (start_ok) begin
            for (int i = 0; i < `FIR_NUM_TAPS; i++) begin
                hist[i] <= '0;
            end
        end else if (in_xfer) begin
            hist[wr_ptr] <= ss_tdata;
        end
    end

    // partial sum and output data
    always_ff @(posedge axis_clk) begin
        if (in_xfer) begin
            acc <= '0;
        end else if (state == fir_pkg::eng_mac) begin
            acc <= sum;
        end
        if (mac_last) begin
            sm_tdata <= sum;
        end
    end

endmodule

`default_nettype wire

/* hdl/fir_top.sv */
// top of the FIR engine, AXI-Lite control plus AXI-Stream in and out; instantiate as the DUT
`timescale 1ns/100ps
`default_nettype none

`include "fir_cfg.svh"

module fir_top (
    input  logic                   axis_clk,
    input  logic                   axis_rst_n,
    input  logic                   awvalid,
    input  logic [`FIR_ADDR_W-1:0] awaddr,
    output logic                   awready,
    input  logic                   wvalid,
    input  logic [`FIR_DATA_W-1:0] wdata,
    output logic                   wready,
    input  logic                   arvalid,
    input  logic [`FIR_ADDR_W-1:0] araddr,
    output logic                   arready,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [`FIR_DATA_W-1:0] rdata,
    input  logic                   ss_tvalid,
    input  logic [`FIR_DATA_W-1:0] ss_tdata,
    // block length comes from the length register, tlast is not looked at
    input  logic                   ss_tlast,
    output logic                   ss_tready,
    output logic                   sm_tvalid,
    output logic [`FIR_DATA_W-1:0] sm_tdata,
    output logic                   sm_tlast,
    input  logic                   sm_tready
);

    fir_pkg::cfg_req_t         cfg_req;
    fir_pkg::run_ctrl_t        run;
    logic [`FIR_DATA_W-1:0]    rd_data;
    logic [`FIR_DATA_W-1:0]    tap_coef;
    logic [`FIR_TAP_IDX_W-1:0] tap_idx;
    logic                      block_done;

    fir_axil_slave i_axil (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .cfg_req    (cfg_req),
        .rd_data    (rd_data)
    );

    fir_ctrl_regs i_regs (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .cfg_req    (cfg_req),
        .rd_data    (rd_data),
        .tap_idx    (tap_idx),
        .tap_coef   (tap_coef),
        .block_done (block_done),
        .run        (run)
    );

    fir_mac_engine i_engine (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .run        (run),
        .tap_idx    (tap_idx),
        .tap_coef   (tap_coef),
        .block_done (block_done),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .sm_tready  (sm_tready)
    );

endmodule

`default_nettype wire

/* tests/fir_tb.sv */
// directed testbench for the FIR engine; drives AXI-Lite and AXI-Stream and checks against a model
`timescale 1ns/100ps
`default_nettype none

`include "fir_cfg.svh"

module fir_tb;

    localparam int max_len = 32;

    logic                   axis_clk;
    logic                   axis_rst_n;
    logic                   awvalid;
    logic [`FIR_ADDR_W-1:0] awaddr;
    logic                   awready;
    logic                   wvalid;
    logic [`FIR_DATA_W-1:0] wdata;
    logic                   wready;
    logic                   arvalid;
    logic [`FIR_ADDR_W-1:0] araddr;
    logic                   arready;
    logic                   rvalid;
    logic                   rready;
    logic [`FIR_DATA_W-1:0] rdata;
    logic                   ss_tvalid;
    logic [`FIR_DATA_W-1:0] ss_tdata;
    logic                   ss_tlast;
    logic                   ss_tready;
    logic                   sm_tvalid;
    logic [`FIR_DATA_W-1:0] sm_tdata;
    logic                   sm_tlast;
    logic                   sm_tready;

    int                     errors;
    int                     timeouts;
    integer                 seed;
    // taps the DUT should be using and the samples of the current block
    logic [`FIR_DATA_W-1:0] taps_ref [`FIR_NUM_TAPS];
    logic [`FIR_DATA_W-1:0] samples [max_len];
    logic [`FIR_DATA_W-1:0] rd_val;

    fir_top i_dut (.*);

    initial begin
        axis_clk = 1'b0;
        forever #5 axis_clk = ~axis_clk;
    end

    // every drive happens just after the rising edge
    task automatic next_cycle();
        @(posedge axis_clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout at %0d ns: gave up waiting for %s", $time, what);
    endtask

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    function automatic logic [`FIR_ADDR_W-1:0] tap_addr(input int i);
        return `FIR_ADDR_TAP0 + (`FIR_ADDR_W)'(4 * i);
    endfunction

    // y[n] is the sum of h[i] * x[n-i] with zero history before the block and a 32-bit wrap
    function automatic logic [`FIR_DATA_W-1:0] expected_out(input int n);
        logic [`FIR_DATA_W-1:0] acc;
        acc = '0;
        for (int i = 0; i < `FIR_NUM_TAPS; i++) begin
            if (n - i >= 0) begin
                acc = acc + taps_ref[i] * samples[n - i];
            end
        end
        return acc;
    endfunction

    task automatic axil_write(input logic [`FIR_ADDR_W-1:0] addr,
                              input logic [`FIR_DATA_W-1:0] data);
        int n;
        n = 0;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        // aw and w are accepted together
        while (!(awready && wready)) begin
            if (n == 50) begin
                report_timeout("awready and wready");
                break;
            end
            next_cycle();
            n++;
        end
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // strobe reaches the register block one cycle later
        next_cycle();
    endtask

    task automatic axil_read(input logic [`FIR_ADDR_W-1:0] addr,
                             output logic [`FIR_DATA_W-1:0] data);
        int n;
        n = 0;
        data    = '0;
        arvalid = 1'b1;
        araddr  = addr;
        while (!arready) begin
            if (n == 50) begin
                report_timeout("arready");
                break;
            end
            next_cycle();
            n++;
        end
        next_cycle();
        arvalid = 1'b0;
        rready  = 1'b1;
        n = 0;
        while (!rvalid) begin
            if (n == 50) begin
                report_timeout("rvalid");
                break;
            end
            next_cycle();
            n++;
        end
        // rdata is stable while rvalid waits on rready
        data = rdata;
        next_cycle();
        rready = 1'b0;
    endtask

    task automatic check_ctrl(input logic exp_done, input logic exp_idle);
        logic [`FIR_DATA_W-1:0] ctrl;
        axil_read(`FIR_ADDR_CTRL, ctrl);
        check_value("ap_done", ctrl[`FIR_BIT_DONE], exp_done);
        check_value("ap_idle", ctrl[`FIR_BIT_IDLE], exp_idle);
    endtask

    task automatic fill_samples(input int len);
        for (int k = 0; k < len; k++) begin
            samples[k] = random_word();
        end
    endtask

    // length write then ap_start
    task automatic start_block(input int len);
        axil_write(`FIR_ADDR_LEN, len);
        axil_write(`FIR_ADDR_CTRL, 32'h1);
    endtask

    // one sample in flight so each sample is followed by its own output
    task automatic stream_block(input int len, input bit random_ready);
        int          n;
        bit          ok;
        logic [31:0] rnd;
        for (int k = 0; k < len; k++) begin
            ok        = 1'b1;
            ss_tvalid = 1'b1;
            ss_tdata  = samples[k];
            ss_tlast  = (k == len - 1);
            n = 0;
            while (!ss_tready) begin
                if (n == 100) begin
                    report_timeout("ss_tready");
                    ok = 1'b0;
                    break;
                end
                next_cycle();
                n++;
            end
            next_cycle();
            ss_tvalid = 1'b0;
            ss_tlast  = 1'b0;
            n = 0;
            rnd = random_word();
            sm_tready = random_ready ? rnd[0] : 1'b1;
            while (ok && !(sm_tvalid && sm_tready)) begin
                if (n == 200) begin
                    report_timeout("an output handshake");
                    ok = 1'b0;
                    break;
                end
                next_cycle();
                n++;
                rnd = random_word();
                sm_tready = random_ready ? rnd[0] : 1'b1;
            end
            if (ok) begin
                check_value($sformatf("sm_tdata of output %0d", k), sm_tdata, expected_out(k));
                check_value($sformatf("sm_tlast of output %0d", k), sm_tlast, k == len - 1);
            end
            next_cycle();
            sm_tready = 1'b0;
            // slot must be empty after the handshake so nothing is duplicated
            check_value("sm_tvalid after handshake", sm_tvalid, 1'b0);
        end
    endtask

    initial begin
        errors     = 0;
        timeouts   = 0;
        seed       = 32'h5cef1b0f;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        ss_tlast   = 1'b0;
        sm_tready  = 1'b0;
        repeat (8) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;
        next_cycle();

        // reset state of the control word
        check_ctrl(1'b0, 1'b1);

        // tap and length read back
        for (int i = 0; i < `FIR_NUM_TAPS; i++) begin
            taps_ref[i] = random_word();
            axil_write(tap_addr(i), taps_ref[i]);
        end
        axil_write(`FIR_ADDR_LEN, 32'd20);
        for (int i = 0; i < `FIR_NUM_TAPS; i++) begin
            axil_read(tap_addr(i), rd_val);
            check_value($sformatf("tap %0d read back", i), rd_val, taps_ref[i]);
        end
        axil_read(`FIR_ADDR_LEN, rd_val);
        check_value("length read back", rd_val, 32'd20);

        // full block with ready always high
        fill_samples(20);
        start_block(20);
        check_ctrl(1'b0, 1'b0);
        stream_block(20, 1'b0);
        check_ctrl(1'b1, 1'b1);

        // back-pressure from the sink
        fill_samples(16);
        start_block(16);
        stream_block(16, 1'b1);
        check_ctrl(1'b1, 1'b1);

        // tap write while running is dropped
        fill_samples(12);
        start_block(12);
        axil_write(tap_addr(3), ~taps_ref[3]);
        axil_read(tap_addr(3), rd_val);
        check_value("tap 3 after write while busy", rd_val, taps_ref[3]);
        stream_block(12, 1'b0);
        check_ctrl(1'b1, 1'b1);

        // next block starts from a cleared history
        fill_samples(8);
        start_block(8);
        stream_block(8, 1'b0);
        check_ctrl(1'b1, 1'b1);

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+hdl
hdl/fir_pkg.sv
hdl/fir_axil_slave.sv
hdl/fir_ctrl_regs.sv
hdl/fir_mac_engine.sv
hdl/fir_top.sv
tests/fir_tb.sv

/* Makefile */
# Verilator flow for the FIR engine

TB  = fir_tb
RTL = fir_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing -f list.f --top-module $(RTL)

obj_dir/V$(TB): list.f hdl/*.sv hdl/*.svh tests/*.sv
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TB)

sim: obj_dir/V$(TB)
	@out=$$(./obj_dir/V$(TB)); \
	echo "$$out"; \
	echo "$$out" | grep -q -F '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
